// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sd_data_engine.f --top-module tb_sd_data_engine -o Vtb_sd_data_engine

status=0
./obj_dir/Vtb_sd_data_engine > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== sd_data_engine.f ====
source/sd_data_pkg.sv
source/sd_crc16_lanes.sv
source/sd_data_tx.sv
source/sd_data_rx.sv
source/sd_data_engine.sv
tb/tb_sd_data_engine.sv

// ==== source/sd_crc16_lanes.sv ====
`timescale 1ns/100ps

module sd_crc16_lanes
    import sd_data_pkg::*;
#(
    parameter int DAT_WIDTH = 4
) (
    input  logic                               PCLK_i,
    input  logic                               PRESETn_i,
    input  logic                               clear_i,   // Zero all lanes
    input  logic                               shift_i,   // Advance by one bit
    input  logic [DAT_WIDTH-1:0]               bits_i,    // One bit per line
    output logic [DAT_WIDTH-1:0][CRC_W-1:0]    crc_o
);

    // One independent CRC per DAT line
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            crc_o <= '0;
        end else if (clear_i) begin
            crc_o <= '0;
        end else if (shift_i) begin
            for (int k = 0; k < DAT_WIDTH; k++) begin
                crc_o[k] <= crc16_step(crc_o[k], bits_i[k]);
            end
        end
    end

    // Users clear before a frame and shift only inside it
    a_no_clear_during_shift: assert property (
        @(posedge PCLK_i) disable iff (!PRESETn_i)
        !(clear_i && shift_i)
    ) else $error("CRC lanes cleared and shifted in the same cycle");

endmodule

// ==== source/sd_data_engine.sv ====
`timescale 1ns/100ps

module sd_data_engine
    import sd_data_pkg::*;
#(
    parameter int DAT_WIDTH   = 4,   // 1 or 4
    parameter int BLOCK_WORDS = 4
) (
    input  logic                 PCLK_i,
    input  logic                 PRESETn_i,
    // Host side
    input  logic                 start_i,
    input  xfer_ctrl_t           ctrl_i,
    output logic                 word_req_o,
    input  logic [WORD_W-1:0]    wr_word_i,
    input  logic                 wr_word_valid_i,
    output logic [WORD_W-1:0]    rd_word_o,
    output logic                 rd_word_valid_o,
    output logic                 busy_o,
    output xfer_status_t         status_o,
    // Card side
    output logic [DAT_WIDTH-1:0] dat_o,
    output logic                 dat_oe_o,
    input  logic [DAT_WIDTH-1:0] dat_i
);

    xfer_ctrl_t   ctrl_q;      // Latched request
    xfer_status_t rx_status;
    logic         busy_q;
    logic         accept;
    logic         tx_start;
    logic         rx_start;
    logic         tx_finish;
    logic         rx_finish;

    // ======================================================================
    // Transfer control
    // ======================================================================
    assign busy_o   = busy_q & ~(tx_finish | rx_finish);  // Low in the done cycle
    assign accept   = start_i & ~busy_o;
    assign tx_start = accept & ctrl_i.write;
    assign rx_start = accept & ~ctrl_i.write;

    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            busy_q <= 1'b0;
            ctrl_q <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            ctrl_q <= ctrl_i;
        end else if (tx_finish || rx_finish) begin
            busy_q <= 1'b0;
        end
    end

    // Status comes from whichever side ran
    always_comb begin
        status_o = rx_status;
        if (ctrl_q.write) begin
            status_o      = '0;
            status_o.done = tx_finish;
        end
    end

    sd_data_tx #(
        .DAT_WIDTH   (DAT_WIDTH),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_tx (
        .PCLK_i       (PCLK_i),
        .PRESETn_i    (PRESETn_i),
        .start_i      (tx_start),
        .word_req_o   (word_req_o),
        .word_i       (wr_word_i),
        .word_valid_i (wr_word_valid_i),
        .dat_o        (dat_o),
        .dat_oe_o     (dat_oe_o),
        .finish_o     (tx_finish)
    );

    sd_data_rx #(
        .DAT_WIDTH   (DAT_WIDTH),
        .BLOCK_WORDS (BLOCK_WORDS)
    ) u_rx (
        .PCLK_i          (PCLK_i),
        .PRESETn_i       (PRESETn_i),
        .start_i         (rx_start),
        .timeout_limit_i (ctrl_q.timeout_limit),
        .dat_i           (dat_i),
        .word_o          (rd_word_o),
        .word_valid_o    (rd_word_valid_o),
        .finish_o        (rx_finish),
        .status_o        (rx_status)
    );

    // Host waits for done before the next request
    a_no_start_when_busy: assert property (
        @(posedge PCLK_i) disable iff (!PRESETn_i)
        busy_o |-> !start_i
    ) else $error("start_i given while busy");

endmodule

// ==== source/sd_data_pkg.sv ====
package sd_data_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int WORD_W    = 32;  // Host word
    localparam int CRC_W     = 16;  // SD data CRC length
    localparam int TIMEOUT_W = 16;  // Start bit wait limit

    localparam logic [CRC_W-1:0] CRC_POLY = 16'h1021;  // x^16 + x^12 + x^5 + 1

    // ======================================================================
    // Frame constants
    // ======================================================================
    localparam logic START_BIT = 1'b0;
    localparam logic END_BIT   = 1'b1;

    // ======================================================================
    // Transfer control and status
    // ======================================================================

    // One transfer request, sampled with start_i
    typedef struct packed {
        logic                 write;          // 1 = host to card
        logic [TIMEOUT_W-1:0] timeout_limit;  // Read only
    } xfer_ctrl_t;

    // Single-cycle flags, valid in the cycle the transfer ends
    typedef struct packed {
        logic done;
        logic crc_error;
        logic end_error;   // End bit sampled as zero
        logic timeout;     // No start bit in time
    } xfer_status_t;

    // Advance one CRC16 by one serial bit
    function automatic logic [CRC_W-1:0] crc16_step(
        input logic [CRC_W-1:0] crc,
        input logic             bit_in
    );
        logic feedback;
        feedback = crc[CRC_W-1] ^ bit_in;
        return {crc[CRC_W-2:0], 1'b0} ^ (feedback ? CRC_POLY : '0);
    endfunction

endpackage

// ==== source/sd_data_rx.sv ====
`timescale 1ns/100ps

module sd_data_rx
    import sd_data_pkg::*;
#(
    parameter int DAT_WIDTH   = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                 PCLK_i,
    input  logic                 PRESETn_i,
    input  logic                 start_i,
    input  logic [TIMEOUT_W-1:0] timeout_limit_i,
    input  logic [DAT_WIDTH-1:0] dat_i,
    output logic [WORD_W-1:0]    word_o,
    output logic                 word_valid_o,
    output logic                 finish_o,
    output xfer_status_t         status_o
);

    localparam int CPW      = WORD_W / DAT_WIDTH;
    localparam int DATA_CYC = BLOCK_WORDS * CPW;
    localparam int CHUNK_W  = $clog2(CPW);
    localparam int CNT_W    = $clog2(DATA_CYC > CRC_W ? DATA_CYC : CRC_W);

    typedef enum logic [2:0] {
        S_IDLE, S_WAIT, S_DATA, S_CRC, S_END
    } rx_state_t;

    rx_state_t                       state;
    logic [CNT_W-1:0]                cnt;
    logic [TIMEOUT_W-1:0]            idle_cnt;  // Cycles without start bit
    logic [WORD_W-1:0]               word_sr;
    logic [DAT_WIDTH-1:0][CRC_W-1:0] rx_crc;    // CRC as sent by the card
    logic [DAT_WIDTH-1:0][CRC_W-1:0] calc_crc;

    assign word_o   = word_sr;  // Complete while word_valid_o is high
    assign finish_o = status_o.done;

    // ======================================================================
    // Receive sequencer
    // ======================================================================
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            state        <= S_IDLE;
            cnt          <= '0;
            idle_cnt     <= '0;
            word_valid_o <= 1'b0;
            status_o     <= '0;
        end else begin
            word_valid_o <= 1'b0;
            status_o     <= '0;
            case (state)
                S_IDLE: begin
                    idle_cnt <= '0;
                    if (start_i) state <= S_WAIT;
                end
                S_WAIT: begin
                    if (dat_i == {DAT_WIDTH{START_BIT}}) begin
                        state <= S_DATA;
                        cnt   <= '0;
                    end else if (idle_cnt + 1'b1 >= timeout_limit_i) begin
                        state            <= S_IDLE;
                        status_o.done    <= 1'b1;
                        status_o.timeout <= 1'b1;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end
                S_DATA: begin
                    cnt <= cnt + 1'b1;
                    // Word is whole once its last chunk is in
                    if (cnt[CHUNK_W-1:0] == CHUNK_W'(CPW - 1)) word_valid_o <= 1'b1;
                    if (cnt == CNT_W'(DATA_CYC - 1)) begin
                        state <= S_CRC;
                        cnt   <= '0;
                    end
                end
                S_CRC: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(CRC_W - 1)) state <= S_END;
                end
                default: begin  // S_END
                    state              <= S_IDLE;
                    status_o.done      <= 1'b1;
                    status_o.crc_error <= (rx_crc != calc_crc);
                    status_o.end_error <= (dat_i != {DAT_WIDTH{END_BIT}});
                end
            endcase
        end
    end

    // Shift registers for data and received CRC
    always_ff @(posedge PCLK_i) begin
        if (state == S_DATA) word_sr <= {word_sr[WORD_W-DAT_WIDTH-1:0], dat_i};
        if (state == S_CRC) begin
            for (int k = 0; k < DAT_WIDTH; k++) begin
                rx_crc[k] <= {rx_crc[k][CRC_W-2:0], dat_i[k]};
            end
        end
    end

    sd_crc16_lanes #(.DAT_WIDTH(DAT_WIDTH)) u_crc (
        .PCLK_i    (PCLK_i),
        .PRESETn_i (PRESETn_i),
        .clear_i   (start_i),
        .shift_i   (state == S_DATA),
        .bits_i    (dat_i),
        .crc_o     (calc_crc)
    );

    // Every strobed word was shifted in entirely during the data phase
    a_word_in_data: assert property (
        @(posedge PCLK_i) disable iff (!PRESETn_i)
        word_valid_o |-> $past(state == S_DATA, CPW)
    ) else $error("Read word strobe without a full word from the data phase");

endmodule

// ==== source/sd_data_tx.sv ====
`timescale 1ns/100ps

module sd_data_tx
    import sd_data_pkg::*;
#(
    parameter int DAT_WIDTH   = 4,
    parameter int BLOCK_WORDS = 4
) (
    input  logic                 PCLK_i,
    input  logic                 PRESETn_i,
    input  logic                 start_i,
    output logic                 word_req_o,
    input  logic [WORD_W-1:0]    word_i,
    input  logic                 word_valid_i,
    output logic [DAT_WIDTH-1:0] dat_o,
    output logic                 dat_oe_o,
    output logic                 finish_o
);

    localparam int CPW      = WORD_W / DAT_WIDTH;       // Chunks per word
    localparam int DATA_CYC = BLOCK_WORDS * CPW;
    localparam int CHUNK_W  = $clog2(CPW);
    localparam int CNT_W    = $clog2(DATA_CYC > CRC_W ? DATA_CYC : CRC_W);
    localparam int CI_W     = $clog2(CRC_W);

    typedef enum logic [2:0] {
        S_IDLE, S_REQ, S_LOAD, S_START, S_DATA, S_CRC, S_END
    } tx_state_t;

    tx_state_t                       state;
    logic [CNT_W-1:0]                cnt;       // Chunk or CRC bit index
    logic [WORD_W-1:0]               shift_q;   // Word being driven
    logic [WORD_W-1:0]               buf_q;     // Next word
    logic [DAT_WIDTH-1:0][CRC_W-1:0] crc;
    logic [CI_W-1:0]                 crc_idx;
    logic                            word_end;
    logic                            last_word;

    assign word_end  = (cnt[CHUNK_W-1:0] == CHUNK_W'(CPW - 1));
    assign last_word = (cnt >= CNT_W'(DATA_CYC - CPW));
    assign crc_idx   = CI_W'(CRC_W - 1) - cnt[CI_W-1:0];  // MSB first

    // Ask early so the buffer is full before the current word runs out
    assign word_req_o = (state == S_REQ) ||
                        (state == S_DATA && cnt[CHUNK_W-1:0] == CHUNK_W'(CPW - 3) &&
                         !last_word);

    // ======================================================================
    // Frame sequencer
    // ======================================================================
    always_ff @(posedge PCLK_i or negedge PRESETn_i) begin
        if (!PRESETn_i) begin
            state    <= S_IDLE;
            cnt      <= '0;
            finish_o <= 1'b0;
        end else begin
            finish_o <= (state == S_END);
            case (state)
                S_IDLE:  if (start_i) state <= S_REQ;
                S_REQ:   state <= S_LOAD;
                S_LOAD:  if (word_valid_i) state <= S_START;  // First word in hand
                S_START: begin
                    state <= S_DATA;
                    cnt   <= '0;
                end
                S_DATA: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(DATA_CYC - 1)) begin
                        state <= S_CRC;
                        cnt   <= '0;
                    end
                end
                S_CRC: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == CNT_W'(CRC_W - 1)) state <= S_END;
                end
                default: state <= S_IDLE;  // S_END
            endcase
        end
    end

    // Word pipeline
    always_ff @(posedge PCLK_i) begin
        if (state == S_LOAD) begin
            shift_q <= word_i;
        end else if (state == S_DATA) begin
            shift_q <= word_end ? buf_q : shift_q << DAT_WIDTH;
        end
        if (word_valid_i && state == S_DATA) buf_q <= word_i;
    end

    sd_crc16_lanes #(.DAT_WIDTH(DAT_WIDTH)) u_crc (
        .PCLK_i    (PCLK_i),
        .PRESETn_i (PRESETn_i),
        .clear_i   (start_i),
        .shift_i   (state == S_DATA),
        .bits_i    (shift_q[WORD_W-1 -: DAT_WIDTH]),
        .crc_o     (crc)
    );

    // Line drivers, idle lines stay high
    always_comb begin
        dat_o = '1;
        case (state)
            S_START: dat_o = {DAT_WIDTH{START_BIT}};
            S_DATA:  dat_o = shift_q[WORD_W-1 -: DAT_WIDTH];
            S_CRC: begin
                for (int k = 0; k < DAT_WIDTH; k++) dat_o[k] = crc[k][crc_idx];
            end
            S_END:   dat_o = {DAT_WIDTH{END_BIT}};
            default: dat_o = '1;
        endcase
    end

    assign dat_oe_o = (state == S_START) || (state == S_DATA) ||
                      (state == S_CRC)   || (state == S_END);

    // Host answers every request on the following cycle
    a_word_after_req: assert property (
        @(posedge PCLK_i) disable iff (!PRESETn_i)
        word_valid_i == $past(word_req_o)
    ) else $error("Write word not supplied one cycle after request");

    a_oe_after_start: assert property (
        @(posedge PCLK_i) disable iff (!PRESETn_i)
        $rose(dat_oe_o) |-> $past(start_i, 3)
    ) else $error("DAT output enabled without a start");

endmodule

// ==== tb/sd_data_testdata.txt ====
# dir (1 write, 0 read)  word0..word3 in hex  crc_flip end_zero start_delay timeout_limit
# crc_flip inverts one CRC bit on one line, end_zero drives the end bit low; decimal columns
# Writes, host supplies the words
1 01234567 89abcdef fedcba98 76543210 0 0 0 0
1 00000000 00000000 00000000 00000000 0 0 0 0
1 ffffffff ffffffff ffffffff ffffffff 0 0 0 0
# Clean reads
0 deadbeef cafef00d 0badc0de 12345678 0 0 0 64
0 a5a55a5a 3c3cc3c3 0f0ff0f0 96696996 0 0 7 64
# Corrupt CRC bit
0 11223344 55667788 99aabbcc ddeeff00 1 0 2 64
# End bit zero
0 13579bdf 2468ace0 fdb97531 eca86420 0 1 4 64
# Start bit later than the limit, then a clean read
0 aaaaaaaa bbbbbbbb cccccccc dddddddd 0 0 40 30
0 0000ffff ffff0000 00ff00ff ff00ff00 0 0 1 30
# Limit boundary, 29 is in time and 30 is late
0 87654321 0fedcba9 10203040 50607080 0 0 29 30
0 01010101 02020202 04040404 08080808 0 0 30 30
# Write after reads
1 c001d00d 0ddba115 b16b00b5 feedface 0 0 0 0
# Both faults in one frame
0 55555555 aaaaaaaa 33333333 cccccccc 1 1 3 64
0 7fffffff 80000000 00000001 fffffffe 0 0 12 20

// ==== tb/tb_sd_data_engine.sv ====
`timescale 1ns/100ps

module tb_sd_data_engine
    import sd_data_pkg::*;
();

    localparam int DAT_W     = 4;
    localparam int BLK_W     = 4;                       // Words per block
    localparam int CPW       = WORD_W / DAT_W;
    localparam int DATA_CYC  = BLK_W * CPW;
    localparam int FRAME_LEN = 1 + DATA_CYC + CRC_W + 1;
    localparam int MAX_REC   = 32;
    localparam int FLIP_LINE = 2;                       // Corrupted CRC line
    localparam int FLIP_CYC  = 5;                       // Corrupted CRC cycle
    localparam logic [CRC_W-1:0] POLY = 16'h1021;

    logic               PCLK_i;
    logic               PRESETn_i;
    logic               start_i;
    xfer_ctrl_t         ctrl_i;
    logic               word_req_o;
    logic [WORD_W-1:0]  wr_word_i;
    logic               wr_word_valid_i;
    logic [WORD_W-1:0]  rd_word_o;
    logic               rd_word_valid_o;
    logic               busy_o;
    xfer_status_t       status_o;
    logic [DAT_W-1:0]   dat_o;
    logic               dat_oe_o;
    logic [DAT_W-1:0]   dat_i;

    logic [WORD_W-1:0]  rec_words [MAX_REC][BLK_W];
    int                 rec_write [MAX_REC];
    int                 rec_flip  [MAX_REC];
    int                 rec_zend  [MAX_REC];
    int                 rec_delay [MAX_REC];
    int                 rec_limit [MAX_REC];
    int                 rec_cnt     = 0;
    int                 errors      = 0;
    int                 cycle_cnt   = 0;
    int                 cycle_limit = 32'h7fff_ffff;
    logic [DAT_W-1:0]   frame [FRAME_LEN];              // Expected DAT line values

    sd_data_engine #(
        .DAT_WIDTH   (DAT_W),
        .BLOCK_WORDS (BLK_W)
    ) uut (.*);

    initial begin
        PCLK_i = 1'b0;
        forever #5 PCLK_i = ~PCLK_i;
    end

    // Watchdog
    always @(posedge PCLK_i) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run exceeded %0d cycles without finishing", cycle_limit);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic next_cycle();
        @(posedge PCLK_i);
        #1;
    endtask

    // ======================================================================
    // Reference model
    // ======================================================================

    // Remainder of the message with 16 zero bits appended
    function automatic logic [CRC_W-1:0] crc16_ref(input logic [DATA_CYC-1:0] bits);
        logic [DATA_CYC+CRC_W-1:0] msg;
        logic [CRC_W-1:0]          rem;
        logic                      msb;
        msg = {bits, {CRC_W{1'b0}}};
        rem = '0;
        for (int i = DATA_CYC + CRC_W - 1; i >= 0; i--) begin
            msb = rem[CRC_W-1];
            rem = {rem[CRC_W-2:0], msg[i]};
            if (msb) rem = rem ^ POLY;
        end
        return rem;
    endfunction

    task automatic build_frame(input int r, input logic flip_crc, input logic zero_end);
        logic [DATA_CYC-1:0] line_bits [DAT_W];
        logic [CRC_W-1:0]    crc;
        logic [WORD_W-1:0]   w;
        int                  pos;
        pos      = 0;
        frame[0] = '0;  // Start bit
        for (int wi = 0; wi < BLK_W; wi++) begin
            w = rec_words[r][wi];
            for (int c = 0; c < CPW; c++) begin
                pos++;
                frame[pos] = w[WORD_W-1 -: DAT_W];  // MSB first
                for (int k = 0; k < DAT_W; k++) line_bits[k][DATA_CYC-pos] = w[WORD_W-DAT_W+k];
                w = w << DAT_W;
            end
        end
        for (int k = 0; k < DAT_W; k++) begin
            crc = crc16_ref(line_bits[k]);
            for (int i = 0; i < CRC_W; i++) frame[DATA_CYC+1+i][k] = crc[CRC_W-1-i];
        end
        if (flip_crc) begin
            frame[DATA_CYC+1+FLIP_CYC][FLIP_LINE] = ~frame[DATA_CYC+1+FLIP_CYC][FLIP_LINE];
        end
        frame[FRAME_LEN-1] = zero_end ? '0 : '1;
    endtask

    task automatic load_records();
        int                fd;
        int                n;
        int                dir, flip, zend, dly, lim;
        logic [WORD_W-1:0] w0, w1, w2, w3;
        string             line;
        fd = $fopen("tb/sd_data_testdata.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the test data file tb/sd_data_testdata.txt");
        end else begin
            cycle_limit = 0;
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%d %h %h %h %h %d %d %d %d",
                            dir, w0, w1, w2, w3, flip, zend, dly, lim);
                if (n == 9 && rec_cnt < MAX_REC) begin  // Comment lines do not parse
                    rec_write[rec_cnt] = dir;
                    rec_words[rec_cnt] = '{w0, w1, w2, w3};
                    rec_flip[rec_cnt]  = flip;
                    rec_zend[rec_cnt]  = zend;
                    rec_delay[rec_cnt] = dly;
                    rec_limit[rec_cnt] = lim;
                    cycle_limit += 2 * (FRAME_LEN + dly + 20);
                    rec_cnt++;
                end
            end
            $fclose(fd);
            if (rec_cnt == 0) begin
                errors++;
                $display("The test data file holds no transfer records");
            end
        end
    endtask

    // ======================================================================
    // Host and card
    // ======================================================================
    task automatic write_block(input int r);
        int   oe_cnt;
        int   req_cnt;
        logic req_q;   // Request seen last cycle
        logic oe_q;
        logic done;
        oe_cnt  = 0;
        req_cnt = 0;
        req_q   = 1'b0;
        oe_q    = 1'b0;
        done    = 1'b0;
        build_frame(r, 1'b0, 1'b0);
        start_i              = 1'b1;
        ctrl_i.write         = 1'b1;
        ctrl_i.timeout_limit = '0;
        next_cycle();
        start_i = 1'b0;
        compare("busy_o", 32'(busy_o), 1);
        while (!done) begin
            if (dat_oe_o) begin
                if (oe_cnt < FRAME_LEN) compare("dat_o", 32'(dat_o), 32'(frame[oe_cnt]));
                oe_cnt++;
            end
            if (status_o.done) begin
                done = 1'b1;
                compare("status_o", 32'(status_o), 32'(4'b1000));
                compare("dat_oe_o before done", 32'(oe_q), 1);
                compare("dat_oe_o cycles", oe_cnt, FRAME_LEN);
                compare("busy_o at done", 32'(busy_o), 0);
            end else begin
                compare("status_o", 32'(status_o), 0);
            end
            wr_word_valid_i = req_q;
            if (req_q) begin
                wr_word_i = (req_cnt < BLK_W) ? rec_words[r][req_cnt] : '0;
                req_cnt++;
            end
            req_q = word_req_o;
            oe_q  = dat_oe_o;
            if (!done) next_cycle();
        end
        compare("word_req_o count", req_cnt, BLK_W);
    endtask

    task automatic read_block(input int r);
        int   n;
        int   rd_cnt;
        int   dly;
        logic to_exp;
        logic crc_exp;
        logic end_exp;
        logic done;
        dly     = rec_delay[r];
        to_exp  = (rec_delay[r] >= rec_limit[r]);  // Start bit later than the limit
        crc_exp = !to_exp && rec_flip[r] != 0;
        end_exp = !to_exp && rec_zend[r] != 0;
        n       = 1;
        rd_cnt  = 0;
        done    = 1'b0;
        build_frame(r, rec_flip[r] != 0, rec_zend[r] != 0);
        start_i              = 1'b1;
        ctrl_i.write         = 1'b0;
        ctrl_i.timeout_limit = TIMEOUT_W'(rec_limit[r]);
        next_cycle();
        start_i = 1'b0;
        compare("busy_o", 32'(busy_o), 1);
        while (!done) begin
            if (rd_word_valid_o) begin
                if (rd_cnt < BLK_W) begin
                    compare("rd_word_o", rd_word_o, rec_words[r][rd_cnt]);
                    // One cycle after the word's last chunk
                    compare("rd_word_valid_o cycle", n, dly + 2 + CPW * (rd_cnt + 1));
                end
                rd_cnt++;
            end
            if (status_o.done) begin
                done = 1'b1;
                compare("status_o", 32'(status_o), 32'({1'b1, crc_exp, end_exp, to_exp}));
                compare("status_o.done cycle", n,
                        to_exp ? rec_limit[r] + 1 : dly + FRAME_LEN + 1);
                compare("busy_o at done", 32'(busy_o), 0);
            end else begin
                compare("status_o", 32'(status_o), 0);
            end
            // Card idles high until its start delay has passed
            if (!to_exp && n > dly && n <= dly + FRAME_LEN) dat_i = frame[n-dly-1];
            else dat_i = '1;
            n++;
            if (!done) next_cycle();
        end
        compare("rd_word_valid_o count", rd_cnt, to_exp ? 0 : BLK_W);
    endtask

    initial begin
        void'($urandom(59637));
        PRESETn_i       = 1'b0;
        start_i         = 1'b0;
        ctrl_i          = '0;
        wr_word_i       = '0;
        wr_word_valid_i = 1'b0;
        dat_i           = '1;
        load_records();
        repeat (3) @(posedge PCLK_i);
        #1 PRESETn_i = 1'b1;

        compare("busy_o", 32'(busy_o), 0);
        compare("dat_oe_o", 32'(dat_oe_o), 0);
        compare("word_req_o", 32'(word_req_o), 0);
        compare("rd_word_valid_o", 32'(rd_word_valid_o), 0);
        compare("status_o", 32'(status_o), 0);
        compare("dat_o", 32'(dat_o), 32'({DAT_W{1'b1}}));

        for (int r = 0; r < rec_cnt; r++) begin
            repeat (1 + $urandom % 4) next_cycle();  // Idle gap
            if (rec_write[r] != 0) write_block(r);
            else read_block(r);
        end
        next_cycle();

        $display("Run complete: %0d records, %0d errors", rec_cnt, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule
